// File: dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int period = 4
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

endmodule

// File: dv/mmc_trace.txt
# op addr wdata wr_mask rd_mask keys expected_rdata
# op is w or r, other columns hex, write lines expect zero data
w 00000010 11223344 f f 00 00000000
w 00000010 aabbccdd 5 f 00 00000000
r 00000010 00000000 0 f 00 11bb33dd
r 00000010 00000000 0 6 00 00bb3300
w 000003fc cafef00d f f 00 00000000
r 000003fc 00000000 0 9 00 ca00000d
w c0000000 000000a5 1 f 00 00000000
r c0000000 00000000 0 f 00 000000a5
w c0000000 0000005a e f 00 00000000
r c1000000 00000000 0 f 3c 0000003c
w c1000000 000000ff 1 f 3c 00000000
r c1000000 00000000 0 f 81 00000081
w c3014000 00000141 1 f 81 00000000
r c3014000 00000000 0 f 81 00000041
w c30144fc 0000127e 1 f 00 00000000
r c30144fc 00000000 0 f 00 0000007e
w 80000000 ffffffff f f 00 00000000
r 80000000 00000000 0 f 00 00000000
w c3014500 ffffffff f f 00 00000000
r c3014500 00000000 0 f 00 00000000
r 00000010 00000000 0 f 00 11bb33dd
r c0000000 00000000 0 f 00 000000a5

// File: dv/tb_mmc_soc.sv
`timescale 1ns/1ps

module tb_mmc_soc;

  localparam int clk_period  = 4;
  localparam int max_latency = 4; // later than this counts as no ack

  logic                          clk;
  logic                          rst;
  logic                          cpu_req;
  logic                          cpu_write;
  logic [31:0]                   cpu_addr;
  logic [31:0]                   cpu_wdata;
  logic [3:0]                    cpu_rd_mask;
  logic [3:0]                    cpu_wr_mask;
  logic                          cpu_ack;
  logic [31:0]                   cpu_rdata;
  logic [mmc_pkg::led_width-1:0] keys;
  logic [mmc_pkg::led_width-1:0] leds;

  logic                          tr_write [$];
  logic [31:0]                   tr_addr [$];
  logic [31:0]                   tr_wdata [$];
  logic [3:0]                    tr_wr_mask [$];
  logic [3:0]                    tr_rd_mask [$];
  logic [mmc_pkg::led_width-1:0] tr_keys [$];
  logic [31:0]                   tr_rdata [$];
  bit                            loaded;
  int                            wd_time;

  clk_gen #(.period (clk_period)) clk_gen_inst (.clk (clk));

  mmc_soc mmc_soc_inst (
    .clk         (clk),
    .rst         (rst),
    .cpu_req     (cpu_req),
    .cpu_write   (cpu_write),
    .cpu_addr    (cpu_addr),
    .cpu_wdata   (cpu_wdata),
    .cpu_rd_mask (cpu_rd_mask),
    .cpu_wr_mask (cpu_wr_mask),
    .cpu_ack     (cpu_ack),
    .cpu_rdata   (cpu_rdata),
    .keys        (keys),
    .leds        (leds)
  );

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("ERR %0t %s actual=%h expected=%h", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "%s does not match", name);
    end
  endtask

  task automatic load_trace();
    int                            fd;
    int                            n;
    string                         line;
    logic [7:0]                    op;
    logic [31:0]                   a;
    logic [31:0]                   wd;
    logic [31:0]                   e;
    logic [3:0]                    wm;
    logic [3:0]                    rm;
    logic [mmc_pkg::led_width-1:0] k;
    fd = $fopen("dv/mmc_trace.txt", "r");
    if (fd == 0)
    begin
      $display("TEST FAILED");
      $fatal(1, "could not open the trace file dv/mmc_trace.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#") // skip column notes
        begin
          n = $sscanf(line, "%s %h %h %h %h %h %h", op, a, wd, wm, rm, k, e);
          if (n == 7)
          begin
            tr_write.push_back(op == "w");
            tr_addr.push_back(a);
            tr_wdata.push_back(wd);
            tr_wr_mask.push_back(wm);
            tr_rd_mask.push_back(rm);
            tr_keys.push_back(k);
            tr_rdata.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // watchdog allows ten cycles per transaction plus reset
  initial
  begin
    wait (loaded);
    #(wd_time);
    $display("TEST FAILED");
    $fatal(1, "timeout, the trace did not finish within %0d ns", wd_time);
  end

  initial
  begin
    int unsigned                   gap;
    int                            lat;
    int                            exp_lat;
    logic [mmc_pkg::led_width-1:0] led_model;
    rst         = 1'b1;
    cpu_req     = 1'b0;
    cpu_write   = 1'b0;
    cpu_addr    = '0;
    cpu_wdata   = '0;
    cpu_rd_mask = '0;
    cpu_wr_mask = '0;
    keys        = '0;
    loaded      = 1'b0;
    led_model   = '0;
    void'($urandom(32'hd20a_4212));
    load_trace();
    wd_time = (tr_addr.size() * 10 + 5) * clk_period;
    loaded  = 1'b1;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    check("cpu_ack", 32'(cpu_ack), 32'h0); // quiet after reset
    check("leds", 32'(leds), 32'h0);
    for (int i = 0; i < tr_addr.size(); i++)
    begin
      keys = tr_keys[i]; // settles through the synchronizer
      gap  = $urandom % 4;
      repeat (4 + gap)
      begin
        @(negedge clk);
        check("cpu_ack", 32'(cpu_ack), 32'h0);
      end
      cpu_req     = 1'b1;
      cpu_write   = tr_write[i];
      cpu_addr    = tr_addr[i];
      cpu_wdata   = tr_wdata[i];
      cpu_wr_mask = tr_wr_mask[i];
      cpu_rd_mask = tr_rd_mask[i];
      exp_lat = (tr_addr[i] >= mmc_pkg::console_addr_lo &&
                 tr_addr[i] <= mmc_pkg::console_addr_hi) ? 2 : 1;
      if (tr_write[i] && tr_wr_mask[i][0] && tr_addr[i] >= mmc_pkg::led_addr_lo &&
          tr_addr[i] <= mmc_pkg::led_addr_hi)
        led_model = tr_wdata[i][mmc_pkg::led_width-1:0];
      @(negedge clk);
      cpu_req = 1'b0;
      lat     = 1;
      while (cpu_ack !== 1'b1 && lat < max_latency)
      begin
        @(negedge clk);
        lat++;
      end
      if (cpu_ack !== 1'b1)
      begin
        $display("TEST FAILED");
        $fatal(1, "no acknowledge for transaction %0d at address %h", i, tr_addr[i]);
      end
      else
      begin
        check("ack latency", 32'(lat), 32'(exp_lat));
        check("cpu_rdata", cpu_rdata, tr_rdata[i]);
        check("leds", 32'(leds), 32'(led_model));
      end
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: mmc_soc.f
rtl/mmc_pkg.sv
rtl/bus_if.sv
rtl/mmc.sv
rtl/ram_slave.sv
rtl/gpio_slave.sv
rtl/console_buffer.sv
rtl/mmc_soc.sv
dv/clk_gen.sv
dv/tb_mmc_soc.sv

// File: rtl/bus_if.sv
`timescale 1ns/1ps

interface bus_if;

  logic        req;     // one-cycle request pulse
  logic        write;
  logic [31:0] addr;    // rebased to region
  logic [31:0] data;
  logic [3:0]  rd_mask;
  logic [3:0]  wr_mask;
  logic        ack;     // one-cycle pulse
  logic [31:0] rdata;   // valid with ack only

  modport master (
    output req,
    output write,
    output addr,
    output data,
    output rd_mask,
    output wr_mask,
    input  ack,
    input  rdata
  );

  modport slave (
    input  req,
    input  write,
    input  addr,
    input  data,
    input  rd_mask,
    input  wr_mask,
    output ack,
    output rdata
  );

endinterface

// File: rtl/console_buffer.sv
`timescale 1ns/1ps

module console_buffer (
  input  logic  clk,
  input  logic  rst,
  bus_if.slave  bus
);

  logic [7:0]                                 mem [mmc_pkg::console_entries];
  logic [$clog2(mmc_pkg::console_entries)-1:0] idx;
  logic [$clog2(mmc_pkg::console_entries)-1:0] rd_idx;
  logic                                       rd_write;
  logic                                       pend;

  assign idx = bus.addr[$clog2(mmc_pkg::console_entries)+1:2];

  always_ff @(posedge clk)
  begin
    if (bus.req && bus.write && bus.wr_mask[0])
      mem[idx] <= bus.data[7:0];
  end

  // first stage latches the index
  always_ff @(posedge clk)
  begin
    if (bus.req)
    begin
      rd_idx   <= idx;
      rd_write <= bus.write;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pend)
      bus.rdata <= rd_write ? 32'h0 : {24'h0, mem[rd_idx]};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pend    <= 1'b0;
      bus.ack <= 1'b0;
    end
    else
    begin
      pend    <= bus.req;
      bus.ack <= pend;
    end
  end

  a_req_to_ack: assert property (@(posedge clk) disable iff (rst)
    bus.req |-> ##2 bus.ack);
  a_ack_from_req: assert property (@(posedge clk) disable iff (rst)
    bus.ack |-> $past(bus.req, 2));

endmodule

// File: rtl/gpio_slave.sv
`timescale 1ns/1ps

module gpio_slave (
  input  logic                          clk,
  input  logic                          rst,
  bus_if.slave                          bus,
  input  logic [mmc_pkg::led_width-1:0] keys,
  output logic [mmc_pkg::led_width-1:0] leds
);

  logic [mmc_pkg::led_width-1:0] key_meta;
  logic [mmc_pkg::led_width-1:0] key_sync;
  logic                          sel_keys;

  assign sel_keys = bus.addr[16];

  // two-flop synchronizer
  always_ff @(posedge clk)
  begin
    key_meta <= keys;
    key_sync <= key_meta;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      leds <= '0;
    else if (bus.req && bus.write && !sel_keys && bus.wr_mask[0])
      leds <= bus.data[mmc_pkg::led_width-1:0];
  end

  always_ff @(posedge clk)
  begin
    if (bus.req)
    begin
      if (bus.write)
        bus.rdata <= 32'h0;
      else if (sel_keys)
        bus.rdata <= {{(32-mmc_pkg::led_width){1'b0}}, key_sync};
      else
        bus.rdata <= {{(32-mmc_pkg::led_width){1'b0}}, leds};
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      bus.ack <= 1'b0;
    else
      bus.ack <= bus.req; // key writes acked too
  end

endmodule

// File: rtl/mmc.sv
`timescale 1ns/1ps

module mmc (
  input  logic        clk,
  input  logic        rst,
  input  logic        cpu_req,
  input  logic        cpu_write,
  input  logic [31:0] cpu_addr,
  input  logic [31:0] cpu_wdata,
  input  logic [3:0]  cpu_rd_mask,
  input  logic [3:0]  cpu_wr_mask,
  output logic        cpu_ack,
  output logic [31:0] cpu_rdata,
  bus_if.master       ram_bus,
  bus_if.master       gpio_bus,
  bus_if.master       console_bus
);

  mmc_pkg::region_e region;
  logic             null_ack;
  logic             outstanding;

  always_comb
  begin
    region = mmc_pkg::region_none;
    if (cpu_addr >= mmc_pkg::mem_addr_lo && cpu_addr <= mmc_pkg::mem_addr_hi)
      region = mmc_pkg::region_ram;
    else if (cpu_addr >= mmc_pkg::led_addr_lo && cpu_addr <= mmc_pkg::led_addr_hi)
      region = mmc_pkg::region_gpio_led;
    else if (cpu_addr >= mmc_pkg::keys_addr_lo && cpu_addr <= mmc_pkg::keys_addr_hi)
      region = mmc_pkg::region_gpio_keys;
    else if (cpu_addr >= mmc_pkg::console_addr_lo && cpu_addr <= mmc_pkg::console_addr_hi)
      region = mmc_pkg::region_console;
  end

  assign ram_bus.req     = cpu_req && (region == mmc_pkg::region_ram);
  assign gpio_bus.req    = cpu_req && (region == mmc_pkg::region_gpio_led ||
                                       region == mmc_pkg::region_gpio_keys);
  assign console_bus.req = cpu_req && (region == mmc_pkg::region_console);

  assign ram_bus.addr     = cpu_addr - mmc_pkg::mem_addr_lo;
  assign gpio_bus.addr    = (region == mmc_pkg::region_gpio_keys) ?
                            ((cpu_addr - mmc_pkg::keys_addr_lo) | 32'h0001_0000) :
                            (cpu_addr - mmc_pkg::led_addr_lo); // bit 16 marks keys
  assign console_bus.addr = cpu_addr - mmc_pkg::console_addr_lo;

  assign ram_bus.write       = cpu_write;
  assign ram_bus.data        = cpu_wdata;
  assign ram_bus.rd_mask     = cpu_rd_mask;
  assign ram_bus.wr_mask     = cpu_wr_mask;
  assign gpio_bus.write      = cpu_write;
  assign gpio_bus.data       = cpu_wdata;
  assign gpio_bus.rd_mask    = cpu_rd_mask;
  assign gpio_bus.wr_mask    = cpu_wr_mask;
  assign console_bus.write   = cpu_write;
  assign console_bus.data    = cpu_wdata;
  assign console_bus.rd_mask = cpu_rd_mask;
  assign console_bus.wr_mask = cpu_wr_mask;

  always_comb
  begin
    cpu_ack   = 1'b0;
    cpu_rdata = '0;
    if (ram_bus.ack)
    begin
      cpu_ack   = 1'b1;
      cpu_rdata = ram_bus.rdata;
    end
    else if (gpio_bus.ack)
    begin
      cpu_ack   = 1'b1;
      cpu_rdata = gpio_bus.rdata;
    end
    else if (console_bus.ack)
    begin
      cpu_ack   = 1'b1;
      cpu_rdata = console_bus.rdata;
    end
    else if (null_ack)
      cpu_ack = 1'b1; // unmapped address returns zero data
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      null_ack    <= 1'b0;
      outstanding <= 1'b0;
    end
    else
    begin
      null_ack <= cpu_req && (region == mmc_pkg::region_none);
      if (cpu_req)
        outstanding <= 1'b1;
      else if (cpu_ack)
        outstanding <= 1'b0;
    end
  end

  a_one_ack: assert property (@(posedge clk) disable iff (rst)
    $onehot0({ram_bus.ack, gpio_bus.ack, console_bus.ack, null_ack}));

  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    cpu_req |-> !outstanding);

endmodule

// File: rtl/mmc_pkg.sv
package mmc_pkg;

  // ram region
  localparam logic [31:0] mem_addr_lo     = 32'h0000_0000;
  localparam logic [31:0] mem_addr_hi     = 32'h0000_03FF;

  // gpio regions both served by gpio_slave
  localparam logic [31:0] led_addr_lo     = 32'hC000_0000;
  localparam logic [31:0] led_addr_hi     = 32'hC000_FFFF;
  localparam logic [31:0] keys_addr_lo    = 32'hC100_0000;
  localparam logic [31:0] keys_addr_hi    = 32'hC100_FFFF;

  // console character buffer with one word per entry
  localparam logic [31:0] console_addr_lo = 32'hC301_4000;
  localparam logic [31:0] console_addr_hi = 32'hC301_44FC;

  localparam int ram_words       = 256; // 1 KiB of words
  localparam int console_entries = 320;
  localparam int led_width       = 8;

  typedef enum logic [2:0] {
    region_ram,
    region_gpio_led,
    region_gpio_keys,
    region_console,
    region_none
  } region_e;

endpackage

// File: rtl/mmc_soc.sv
`timescale 1ns/1ps

module mmc_soc (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cpu_req,
  input  logic                          cpu_write,
  input  logic [31:0]                   cpu_addr,
  input  logic [31:0]                   cpu_wdata,
  input  logic [3:0]                    cpu_rd_mask,
  input  logic [3:0]                    cpu_wr_mask,
  output logic                          cpu_ack,
  output logic [31:0]                   cpu_rdata,
  input  logic [mmc_pkg::led_width-1:0] keys,
  output logic [mmc_pkg::led_width-1:0] leds
);

  bus_if ram_bus ();
  bus_if gpio_bus ();
  bus_if console_bus ();

  mmc mmc_inst (
    .clk         (clk),
    .rst         (rst),
    .cpu_req     (cpu_req),
    .cpu_write   (cpu_write),
    .cpu_addr    (cpu_addr),
    .cpu_wdata   (cpu_wdata),
    .cpu_rd_mask (cpu_rd_mask),
    .cpu_wr_mask (cpu_wr_mask),
    .cpu_ack     (cpu_ack),
    .cpu_rdata   (cpu_rdata),
    .ram_bus     (ram_bus.master),
    .gpio_bus    (gpio_bus.master),
    .console_bus (console_bus.master)
  );

  ram_slave #(
    .words (mmc_pkg::ram_words)
  ) ram_slave_inst (
    .clk (clk),
    .rst (rst),
    .bus (ram_bus.slave)
  );

  gpio_slave gpio_slave_inst (
    .clk  (clk),
    .rst  (rst),
    .bus  (gpio_bus.slave),
    .keys (keys),
    .leds (leds)
  );

  console_buffer console_buffer_inst (
    .clk (clk),
    .rst (rst),
    .bus (console_bus.slave)
  );

endmodule

// File: rtl/ram_slave.sv
`timescale 1ns/1ps

module ram_slave #(
  parameter int words = 256
) (
  input  logic  clk,
  input  logic  rst,
  bus_if.slave  bus
);

  logic [31:0]                mem [words];
  logic [$clog2(words)-1:0]   idx;
  logic [31:0]                rd_word;

  assign idx = bus.addr[$clog2(words)+1:2]; // word offset

  always_comb
  begin
    for (int b = 0; b < 4; b++)
    begin
      rd_word[8*b +: 8] = bus.rd_mask[b] ? mem[idx][8*b +: 8] : 8'h00;
    end
  end

  always_ff @(posedge clk)
  begin
    if (bus.req && bus.write)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (bus.wr_mask[b])
          mem[idx][8*b +: 8] <= bus.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (bus.req)
      bus.rdata <= bus.write ? 32'h0 : rd_word; // write acks carry zero
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      bus.ack <= 1'b0;
    else
      bus.ack <= bus.req;
  end

  a_in_range: assert property (@(posedge clk) disable iff (rst)
    bus.req |-> (bus.addr[31:2] < words));

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the mmc_soc testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_mmc_soc \
  -Mdir obj_dir \
  -f mmc_soc.f

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/Vtb_mmc_soc
